//--- flist.f
mm_pkg.sv
mont_task_if.sv
operand_loader.sv
rho_precalc.sv
mont_mul_r2.sv
mm_sequencer.sv
mm_top.sv
tb_clock_gen.sv
tb_mm_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mm_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_mm_top.sv
module tb_mm_top;

    localparam int n_jobs      = 32;
    localparam int job_cyc     = mm_pkg::num_words*4 + 4*(mm_pkg::op_w+2) + 20;
    localparam int wd_limit    = n_jobs*job_cyc + 2*mm_pkg::op_w + 1000;
    localparam int ready_limit = 2*mm_pkg::op_w + 10;

    logic             clk, rst_n;
    logic             mm_start, mm_x_valid, mm_y_valid, mm_valid, mm_ready;
    mm_pkg::word_t    mm_x, mm_y, mm_result;
    int               err_cnt, jobs_issued, frames_seen, run_len, since_rst;
    logic             ready_seen, frame_done;
    mm_pkg::operand_t frame_sh, exp_val, x_arg, y_arg;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    mm_top dut0 (
        .clk(clk), .rst_n(rst_n), .mm_start(mm_start),
        .mm_x(mm_x), .mm_x_valid(mm_x_valid), .mm_y(mm_y), .mm_y_valid(mm_y_valid),
        .mm_result(mm_result), .mm_valid(mm_valid), .mm_ready(mm_ready)
    );

    task automatic report_check(input string msg);
        err_cnt++;
        $display("CHECK FAILED @%0t: %s", $time, msg);
    endtask

    // plain x*y mod m, double width
    function automatic mm_pkg::operand_t ref_modmul(input mm_pkg::operand_t x,
                                                    input mm_pkg::operand_t y);
        logic [2*mm_pkg::op_w-1:0] prod;
        prod = {{mm_pkg::op_w{1'b0}}, x} * {{mm_pkg::op_w{1'b0}}, y};
        prod = prod % {{mm_pkg::op_w{1'b0}}, mm_pkg::modulus};
        return prod[mm_pkg::op_w-1:0];
    endfunction

    function automatic mm_pkg::operand_t rand_operand();
        mm_pkg::operand_t r;
        r = {$urandom, $urandom};
        return r % mm_pkg::modulus;
    endfunction

    // --------------------
    // result collector
    // --------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_len     <= 0;
            frame_done  <= 1'b0;
            frames_seen <= 0;
            since_rst   <= 0;
            ready_seen  <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (mm_valid) begin
                frame_sh <= {mm_result, frame_sh[mm_pkg::op_w-1:mm_pkg::word_w]};
                run_len  <= run_len + 1;
                if (run_len == mm_pkg::num_words - 1) begin
                    frame_done  <= 1'b1;
                    frames_seen <= frames_seen + 1;
                end
            end else begin
                run_len <= 0;
            end
            if (mm_ready)
                ready_seen <= 1'b1;
            if (!ready_seen)
                since_rst <= since_rst + 1;
        end
    end

    // --------------------
    // checks
    // --------------------
    a_rst_ready: assert property (@(posedge clk) !rst_n |-> !mm_ready)
        else report_check("mm_ready high in reset");
    a_ready_late: assert property (@(posedge clk) (rst_n && !ready_seen) |-> since_rst < ready_limit)
        else report_check("mm_ready late after reset");
    a_idle_valid: assert property (@(posedge clk) (jobs_issued == 0) |-> !mm_valid)
        else report_check("mm_valid before any job");
    a_busy_out: assert property (@(posedge clk) mm_valid |-> !mm_ready)
        else report_check("mm_ready high during output");
    a_frame_long: assert property (@(posedge clk) mm_valid |-> run_len < mm_pkg::num_words)
        else report_check("output frame too long");
    a_frame_short: assert property (@(posedge clk)
                                    (!mm_valid && run_len != 0) |-> run_len == mm_pkg::num_words)
        else report_check("output frame too short");
    a_result: assert property (@(posedge clk) frame_done |-> frame_sh == exp_val)
        else report_check($sformatf("result %h expected %h", frame_sh, exp_val));
    a_extra: assert property (@(posedge clk) frame_done |-> frames_seen <= jobs_issued)
        else report_check("result frame without a job");

    task automatic wait_ready();
        while (!mm_ready)
            @(posedge clk);
    endtask

    task automatic run_job(input string name, input mm_pkg::operand_t x,
                           input mm_pkg::operand_t y, input bit irregular, input bit poke_busy);
        int xi, yi, n_words, prev_err;
        prev_err = err_cnt;
        n_words  = irregular ? mm_pkg::num_words + 1 : mm_pkg::num_words;
        if (irregular) begin   // stray words, dropped by the loader
            mm_x       <= mm_pkg::word_t'($urandom);
            mm_y       <= mm_pkg::word_t'($urandom);
            mm_x_valid <= 1'b1;
            mm_y_valid <= 1'b1;
            @(posedge clk);
            mm_x_valid <= 1'b0;
            mm_y_valid <= 1'b0;
        end
        @(posedge clk);
        wait_ready();
        exp_val = ref_modmul(x, y);
        jobs_issued++;
        mm_start <= 1'b1;
        @(posedge clk);
        mm_start <= 1'b0;
        xi = 0;
        yi = 0;
        while (xi < n_words || yi < n_words) begin
            mm_x_valid <= 1'b0;
            mm_y_valid <= 1'b0;
            if (xi < n_words && (!irregular || $urandom % 2 == 1)) begin
                mm_x <= (xi < mm_pkg::num_words) ? x[xi*mm_pkg::word_w +: mm_pkg::word_w]
                                                 : mm_pkg::word_t'($urandom);
                mm_x_valid <= 1'b1;
                xi++;
            end
            if (yi < n_words && (!irregular || $urandom % 2 == 1)) begin
                mm_y <= (yi < mm_pkg::num_words) ? y[yi*mm_pkg::word_w +: mm_pkg::word_w]
                                                 : mm_pkg::word_t'($urandom);
                mm_y_valid <= 1'b1;
                yi++;
            end
            @(posedge clk);
        end
        mm_x_valid <= 1'b0;
        mm_y_valid <= 1'b0;
        if (poke_busy) begin   // start while the passes run
            repeat (10) @(posedge clk);
            mm_start <= 1'b1;
            @(posedge clk);
            mm_start <= 1'b0;
        end
        while (frames_seen < jobs_issued)
            @(posedge clk);
        @(posedge clk);   // let the result check settle
        $display("test %0d %s: %s", jobs_issued, name, (err_cnt == prev_err) ? "ok" : "failed");
    endtask

    initial begin
        int i;
        void'($urandom(32'h6ee7ed15));
        mm_start   = 1'b0;
        mm_x       = '0;
        mm_y       = '0;
        mm_x_valid = 1'b0;
        mm_y_valid = 1'b0;
        @(posedge clk);
        while (!rst_n)
            @(posedge clk);
        run_job("zero", '0, mm_pkg::operand_t'(5), 1'b0, 1'b0);
        run_job("one", mm_pkg::operand_t'(1), mm_pkg::operand_t'(1), 1'b0, 1'b0);
        run_job("max", mm_pkg::modulus - 1, mm_pkg::modulus - 1, 1'b0, 1'b0);
        x_arg = (mm_pkg::operand_t'(1) << (mm_pkg::op_w - 1)) % mm_pkg::modulus;
        run_job("top bit", x_arg, x_arg, 1'b0, 1'b0);
        for (i = 0; i < 20; i++) begin
            x_arg = rand_operand();
            y_arg = rand_operand();
            run_job("random", x_arg, y_arg, 1'b0, 1'b0);
        end
        for (i = 0; i < 8; i++) begin
            x_arg = rand_operand();
            y_arg = rand_operand();
            run_job(i < 6 ? "irregular" : "busy start", x_arg, y_arg, i != 6, i >= 6);
        end
        repeat (job_cyc) @(posedge clk);   // room for a stray frame
        $display("jobs %0d, frames %0d, failed checks %0d", jobs_issued, frames_seen, err_cnt);
        if (err_cnt == 0 && frames_seen == jobs_issued)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // --------------------
    // watchdog
    // --------------------
    initial begin
        repeat (wd_limit) @(posedge clk);
        $display("timeout: run still going after %0d cycles", wd_limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 unit period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- mm_top.sv
module mm_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          mm_start,
    input  mm_pkg::word_t mm_x,
    input  logic          mm_x_valid,
    input  mm_pkg::word_t mm_y,
    input  logic          mm_y_valid,
    output mm_pkg::word_t mm_result,
    output logic          mm_valid,
    output logic          mm_ready
);

    mm_pkg::operand_t x_op;
    mm_pkg::operand_t y_op;
    mm_pkg::operand_t rho;
    logic             rho_ready;
    logic             operands_ready;
    logic             loader_clear;

    mont_task_if mont_task ();

    operand_loader u_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear          (loader_clear),
        .x_word         (mm_x),
        .y_word         (mm_y),
        .x_valid        (mm_x_valid),
        .y_valid        (mm_y_valid),
        .x_op           (x_op),
        .y_op           (y_op),
        .operands_ready (operands_ready)
    );

    rho_precalc u_rho (
        .clk       (clk),
        .rst_n     (rst_n),
        .rho       (rho),
        .rho_ready (rho_ready)
    );

    mm_sequencer u_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .mm_start       (mm_start),
        .rho            (rho),
        .rho_ready      (rho_ready),
        .x_op           (x_op),
        .y_op           (y_op),
        .operands_ready (operands_ready),
        .loader_clear   (loader_clear),
        .mm_ready       (mm_ready),
        .mm_result      (mm_result),
        .mm_valid       (mm_valid),
        .mont_task      (mont_task.seq)
    );

    mont_mul_r2 u_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .mont_task (mont_task.core)
    );

endmodule

//--- mm_sequencer.sv
module mm_sequencer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mm_start,
    input  mm_pkg::operand_t rho,
    input  logic             rho_ready,
    input  mm_pkg::operand_t x_op,
    input  mm_pkg::operand_t y_op,
    input  logic             operands_ready,
    output logic             loader_clear,
    output logic             mm_ready,
    output mm_pkg::word_t    mm_result,
    output logic             mm_valid,
    mont_task_if.seq         mont_task
);

    mm_pkg::mm_state_e state;
    mm_pkg::operand_t  r1;       // x in montgomery form
    mm_pkg::operand_t  out_sh;   // result shifter
    mm_pkg::word_idx_t word_cnt;

    assign mm_ready     = (state == mm_pkg::idle) && rho_ready;
    assign loader_clear = mm_ready && mm_start;
    assign mm_valid     = (state == mm_pkg::send);
    assign mm_result    = out_sh[mm_pkg::word_w-1:0];

    // --------------------
    // pass control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= mm_pkg::idle;
            mont_task.start <= 1'b0;
            word_cnt        <= '0;
        end else begin
            mont_task.start <= 1'b0;
            case (state)
                mm_pkg::idle: begin
                    if (loader_clear)
                        state <= mm_pkg::wait_rho;
                end
                mm_pkg::wait_rho: begin
                    if (operands_ready) begin
                        mont_task.start <= 1'b1;
                        state           <= mm_pkg::x_rho;
                    end
                end
                mm_pkg::x_rho: begin
                    if (mont_task.done) begin
                        mont_task.start <= 1'b1;
                        state           <= mm_pkg::y_rho;
                    end
                end
                mm_pkg::y_rho: begin
                    if (mont_task.done) begin
                        mont_task.start <= 1'b1;
                        state           <= mm_pkg::r1_r2;
                    end
                end
                mm_pkg::r1_r2: begin
                    if (mont_task.done) begin
                        mont_task.start <= 1'b1;
                        state           <= mm_pkg::r3_1;
                    end
                end
                mm_pkg::r3_1: begin
                    if (mont_task.done) begin
                        word_cnt <= '0;
                        state    <= mm_pkg::send;
                    end
                end
                mm_pkg::send: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == mm_pkg::word_idx_t'(mm_pkg::num_words - 1))
                        state <= mm_pkg::idle;
                end
                default: state <= mm_pkg::idle;
            endcase
        end
    end

    // --------------------
    // operands and results
    // --------------------
    always_ff @(posedge clk) begin
        case (state)
            mm_pkg::wait_rho: begin
                mont_task.a <= x_op;
                mont_task.b <= rho;
            end
            mm_pkg::x_rho: begin
                if (mont_task.done) begin
                    r1          <= mont_task.res;
                    mont_task.a <= y_op;
                end
            end
            mm_pkg::y_rho: begin
                if (mont_task.done) begin
                    mont_task.a <= r1;
                    mont_task.b <= mont_task.res;   // r2
                end
            end
            mm_pkg::r1_r2: begin
                if (mont_task.done) begin
                    mont_task.a <= mont_task.res;   // r3
                    mont_task.b <= mm_pkg::operand_t'(1);
                end
            end
            mm_pkg::r3_1: begin
                if (mont_task.done)
                    out_sh <= mont_task.res;
            end
            mm_pkg::send: out_sh <= out_sh >> mm_pkg::word_w;   // low word first
            default: ;
        endcase
    end

endmodule

//--- mont_mul_r2.sv
module mont_mul_r2 (
    input  logic        clk,
    input  logic        rst_n,
    mont_task_if.core   mont_task
);

    logic [$clog2(mm_pkg::op_w)-1:0] bit_cnt;
    logic                            busy;
    logic                            fin;   // subtract cycle
    logic [mm_pkg::op_w:0]           sum;   // stays below 2*modulus
    logic [mm_pkg::op_w+1:0]         acc_add;
    logic [mm_pkg::op_w+1:0]         acc_q;
    logic [mm_pkg::op_w:0]           sum_red;

    // --------------------
    // one radix-2 step
    // --------------------
    always_comb begin
        acc_add = {1'b0, sum};
        if (mont_task.a[bit_cnt])
            acc_add = acc_add + {2'b00, mont_task.b};
        acc_q = acc_add;
        if (acc_add[0])
            acc_q = acc_add + {2'b00, mm_pkg::modulus};   // make it even
    end

    assign sum_red = sum - {1'b0, mm_pkg::modulus};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            fin            <= 1'b0;
            bit_cnt        <= '0;
            mont_task.done <= 1'b0;
        end else begin
            mont_task.done <= 1'b0;
            fin            <= 1'b0;
            if (mont_task.start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (&bit_cnt) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end
            if (fin)
                mont_task.done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mont_task.start)
            sum <= '0;
        else if (busy)
            sum <= acc_q[mm_pkg::op_w+1:1];   // halve
        if (fin)
            mont_task.res <= (sum >= {1'b0, mm_pkg::modulus}) ?
                             sum_red[mm_pkg::op_w-1:0] : sum[mm_pkg::op_w-1:0];
    end

endmodule

//--- rho_precalc.sv
module rho_precalc (
    input  logic             clk,
    input  logic             rst_n,
    output mm_pkg::operand_t rho,
    output logic             rho_ready
);

    // 2*op_w doublings, counter wraps at all ones
    logic [$clog2(2*mm_pkg::op_w)-1:0] dbl_cnt;
    mm_pkg::operand_t                  acc;
    logic [mm_pkg::op_w:0]             dbl;
    logic [mm_pkg::op_w:0]             dbl_red;
    logic                              dbl_ge;

    assign dbl     = {acc, 1'b0};
    assign dbl_red = dbl - {1'b0, mm_pkg::modulus};
    assign dbl_ge  = (dbl >= {1'b0, mm_pkg::modulus});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= mm_pkg::operand_t'(1);
            dbl_cnt   <= '0;
            rho_ready <= 1'b0;
        end else if (!rho_ready) begin
            acc     <= dbl_ge ? dbl_red[mm_pkg::op_w-1:0] : dbl[mm_pkg::op_w-1:0];
            dbl_cnt <= dbl_cnt + 1'b1;
            if (&dbl_cnt)
                rho_ready <= 1'b1;   // last doubling
        end
    end

    assign rho = acc;

endmodule

//--- operand_loader.sv
module operand_loader (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  mm_pkg::word_t    x_word,
    input  mm_pkg::word_t    y_word,
    input  logic             x_valid,
    input  logic             y_valid,
    output mm_pkg::operand_t x_op,
    output mm_pkg::operand_t y_op,
    output logic             operands_ready
);

    mm_pkg::word_idx_t x_cnt;
    mm_pkg::word_idx_t y_cnt;
    logic              fired;   // ready already given for this job
    logic              x_full;
    logic              y_full;

    assign x_full = (x_cnt == mm_pkg::word_idx_t'(mm_pkg::num_words));
    assign y_full = (y_cnt == mm_pkg::word_idx_t'(mm_pkg::num_words));

    // counters sit full after reset so stray words are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt          <= mm_pkg::word_idx_t'(mm_pkg::num_words);
            y_cnt          <= mm_pkg::word_idx_t'(mm_pkg::num_words);
            fired          <= 1'b1;
            operands_ready <= 1'b0;
        end else if (clear) begin
            x_cnt          <= '0;
            y_cnt          <= '0;
            fired          <= 1'b0;
            operands_ready <= 1'b0;
        end else begin
            if (x_valid && !x_full)
                x_cnt <= x_cnt + 1'b1;
            if (y_valid && !y_full)
                y_cnt <= y_cnt + 1'b1;
            operands_ready <= x_full && y_full && !fired;
            if (x_full && y_full)
                fired <= 1'b1;
        end
    end

    // word slots, low word first
    always_ff @(posedge clk) begin
        if (x_valid && !x_full && !clear)
            x_op[x_cnt*mm_pkg::word_w +: mm_pkg::word_w] <= x_word;
        if (y_valid && !y_full && !clear)
            y_op[y_cnt*mm_pkg::word_w +: mm_pkg::word_w] <= y_word;
    end

endmodule

//--- mont_task_if.sv
interface mont_task_if;

    logic             start;   // one-cycle strobe
    mm_pkg::operand_t a;
    mm_pkg::operand_t b;
    logic             done;    // one-cycle strobe
    mm_pkg::operand_t res;     // valid with done

    modport seq (
        output start, a, b,
        input  done, res
    );

    modport core (
        input  start, a, b,
        output done, res
    );

endinterface

//--- mm_pkg.sv
package mm_pkg;

    // --------------------
    // operand geometry
    // --------------------
    localparam int word_w     = 16;
    localparam int num_words  = 4;
    localparam int op_w       = word_w * num_words;
    localparam int word_idx_w = $clog2(num_words + 1);   // counts 0..num_words

    // fixed odd modulus, msb set
    localparam logic [op_w-1:0] modulus = 64'hd8f3_51a7_26bc_e94b;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [op_w-1:0]       operand_t;
    typedef logic [word_idx_w-1:0] word_idx_t;

    // --------------------
    // sequencer states
    // --------------------
    typedef enum logic [2:0] {
        idle,
        wait_rho,   // waiting for operands
        x_rho,
        y_rho,
        r1_r2,
        r3_1,
        send
    } mm_state_e;

endpackage
